//--- Bender.yml
package:
  name: enc_s4

sources:
  - verilog/enc_s4_pkg.sv
  - verilog/s4_reset_control.sv
  - verilog/final_bits_generator.sv
  - verilog/carry_propagation.sv
  - verilog/stage_4.sv
  - target: test
    files:
      - tb/tb_stage_4.sv

//--- files.f
verilog/enc_s4_pkg.sv
verilog/s4_reset_control.sv
verilog/final_bits_generator.sv
verilog/carry_propagation.sv
verilog/stage_4.sv
tb/tb_stage_4.sv

//--- tb/tb_stage_4.sv
// Testbench for stage 4 with clock, reset, stream stimulus, reference model and compare process
`timescale 1ns/10ps
`default_nettype none

module tb_stage_4;

  typedef logic [enc_s4_pkg::BYTE_WIDTH-1:0]  byte_t;
  typedef logic [enc_s4_pkg::RANGE_WIDTH-1:0] chunk_t;
  typedef byte_t  byte_q_t [$];
  typedef chunk_t chunk_q_t [$];

  localparam logic [31:0] SEED           = 32'ha6a6aeea;
  localparam int          TIMEOUT_CYCLES = 200;

  logic                                 s4_clk;
  logic                                 rst_n;
  logic                                 flush;
  enc_s4_pkg::chunk_cnt_e               in_arith_flag;
  chunk_t                               in_arith_bitstream_1;
  chunk_t                               in_arith_bitstream_2;
  logic [enc_s4_pkg::LOW_WIDTH-1:0]     in_arith_low;
  logic [enc_s4_pkg::D_SIZE-1:0]        in_arith_cnt;
  byte_t                                out_carry_bit_1;
  byte_t                                out_carry_bit_2;
  byte_t                                out_carry_bit_3;
  byte_t                                out_carry_bit_4;
  byte_t                                out_carry_bit_5;
  logic [enc_s4_pkg::OUT_CNT_WIDTH-1:0] out_carry_flag_bitstream;
  logic                                 output_flag_last;

  int       mismatch_cnt  = 0;
  int       fail_cnt      = 0;
  int       bytes_checked = 0;
  int       streams_sent  = 0;
  int       streams_done  = 0;
  int       ff_run        = 0;
  bit       stream_first  = 1'b1;
  bit       checking      = 1'b0;
  bit       lanes_seen    = 1'b0;
  logic [2:0] flush_hist;
  byte_t    prev_lanes [enc_s4_pkg::OUT_SLOTS];
  chunk_q_t stream_chunks;
  byte_q_t  exp_q;
  int       exp_len [$];
  byte_q_t  got_q;

  stage_4 DUT (
    .s4_clk                   (s4_clk),
    .rst_n                    (rst_n),
    .flush                    (flush),
    .in_arith_flag            (in_arith_flag),
    .in_arith_bitstream_1     (in_arith_bitstream_1),
    .in_arith_bitstream_2     (in_arith_bitstream_2),
    .in_arith_low             (in_arith_low),
    .in_arith_cnt             (in_arith_cnt),
    .out_carry_bit_1          (out_carry_bit_1),
    .out_carry_bit_2          (out_carry_bit_2),
    .out_carry_bit_3          (out_carry_bit_3),
    .out_carry_bit_4          (out_carry_bit_4),
    .out_carry_bit_5          (out_carry_bit_5),
    .out_carry_flag_bitstream (out_carry_flag_bitstream),
    .output_flag_last         (output_flag_last)
  );

  initial begin
    s4_clk = 1'b0;
    forever #50 s4_clk = ~s4_clk;
  end

  // ---------------------------------------------------------------------
  // Compare tasks
  // ---------------------------------------------------------------------
  task automatic check_byte(string name, byte_t got, byte_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH %0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic check_count(string name, logic [enc_s4_pkg::OUT_CNT_WIDTH-1:0] got,
                             logic [enc_s4_pkg::OUT_CNT_WIDTH-1:0] exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH %0t %s got %0d exp %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_last(string name, logic got, logic exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH %0t %s got %b exp %b", $time, name, got, exp);
    end
  endtask

  // ---------------------------------------------------------------------
  // Reference model
  // ---------------------------------------------------------------------
  // Chunk rules over the stream, then the final chunks, then the drain
  function automatic byte_q_t expected_bytes(chunk_q_t chunks,
                                             logic [enc_s4_pkg::LOW_WIDTH-1:0] low,
                                             logic [enc_s4_pkg::D_SIZE-1:0] cnt);
    byte_q_t  res;
    chunk_q_t all;
    byte_t    held;
    bit       held_ok;
    int       pend;
    chunk_t   c;
    all     = chunks;
    held    = '0;
    held_ok = 1'b0;
    pend    = 0;
    all.push_back(chunk_t'({low[23], low[22:15]}));
    if (cnt > 8) begin
      all.push_back(chunk_t'(low[14:7]));
    end
    foreach (all[i]) begin
      c = all[i];
      if (!held_ok) begin
        held    = c[7:0];
        held_ok = 1'b1;
      end else if (c == 16'h00FF) begin
        pend++;
      end else begin
        res.push_back(byte_t'(held + byte_t'(c[8])));
        repeat (pend) res.push_back(c[8] ? 8'h00 : 8'hFF);
        held = c[7:0];
        pend = 0;
      end
    end
    res.push_back(held);
    repeat (pend) res.push_back(8'hFF);
    return res;
  endfunction

  // ---------------------------------------------------------------------
  // Stimulus
  // ---------------------------------------------------------------------
  // Runs of 0x0FF stay within the pending limit, a stream opens with a plain byte
  function automatic chunk_t draw_chunk(bit first, bit use_ff, bit use_carry);
    byte_t b;
    logic  c;
    b = 8'($urandom);
    c = use_carry && !first && ($urandom % 3 == 0);
    if (!first && use_ff && ff_run < enc_s4_pkg::MAX_PENDING && $urandom % 3 == 0) begin
      ff_run++;
      return 16'h00FF;
    end
    if (!c && b == 8'hFF) begin
      b = 8'hFE;
    end
    ff_run = 0;
    return {7'b0, c, b};
  endfunction

  task automatic send_group(enc_s4_pkg::chunk_cnt_e cnt, bit use_ff, bit use_carry);
    chunk_t c1;
    chunk_t c2;
    c1 = '0;
    c2 = '0;
    if (cnt != enc_s4_pkg::CHUNK_NONE) begin
      c1 = draw_chunk(stream_first, use_ff, use_carry);
      stream_first = 1'b0;
      stream_chunks.push_back(c1);
    end
    if (cnt == enc_s4_pkg::CHUNK_TWO) begin
      c2 = draw_chunk(1'b0, use_ff, use_carry);
      stream_chunks.push_back(c2);
    end
    @(negedge s4_clk);
    in_arith_flag        = cnt;
    in_arith_bitstream_1 = c1;
    in_arith_bitstream_2 = c2;
  endtask

  // Flush, then the two quiet cycles before a new stream may start
  task automatic send_flush(logic [enc_s4_pkg::D_SIZE-1:0] cnt, bit tail_ff);
    logic [enc_s4_pkg::LOW_WIDTH-1:0] low;
    byte_q_t                          e;
    low = 24'($urandom);
    // A final first byte of 0xFF could stretch the pending run past its limit
    if (low[22:15] == 8'hFF) low[15] = 1'b0;
    // A second byte of 0xFF stays pending until the drain
    if (tail_ff) low[14:7] = 8'hFF;
    e = expected_bytes(stream_chunks, low, cnt);
    foreach (e[i]) exp_q.push_back(e[i]);
    exp_len.push_back(e.size());
    stream_chunks = {};
    stream_first  = 1'b1;
    ff_run        = 0;
    streams_sent++;
    @(negedge s4_clk);
    in_arith_flag = enc_s4_pkg::CHUNK_NONE;
    flush         = 1'b1;
    in_arith_low  = low;
    in_arith_cnt  = cnt;
    @(negedge s4_clk);
    flush = 1'b0;
    @(negedge s4_clk);
  endtask

  task automatic random_stream(int groups);
    send_group(enc_s4_pkg::CHUNK_TWO, 1'b1, 1'b1);
    repeat (groups - 1) begin
      send_group(enc_s4_pkg::chunk_cnt_e'($urandom % 3), 1'b1, 1'b1);
    end
    send_flush(5'($urandom), 1'b0);
  endtask

  // ---------------------------------------------------------------------
  // Compare process
  // ---------------------------------------------------------------------
  always @(posedge s4_clk) begin
    if (!rst_n) begin
      flush_hist <= '0;
    end else begin
      flush_hist <= {flush_hist[1:0], flush};
    end
  end

  task automatic finish_stream();
    int len;
    if (exp_len.size() == 0) begin
      fail_cnt++;
      $display("ERROR %0t last flag raised with no stream flushed", $time);
    end else begin
      len = exp_len.pop_front();
      if (got_q.size() != len) begin
        fail_cnt++;
        $display("ERROR %0t stream %0d gave %0d bytes where %0d were expected",
                 $time, streams_done, got_q.size(), len);
      end
      for (int i = 0; i < len && i < got_q.size(); i++) begin
        check_byte($sformatf("stream %0d byte %0d", streams_done, i), got_q[i], exp_q[i]);
        bytes_checked++;
      end
      repeat (len) void'(exp_q.pop_front());
      got_q = {};
      streams_done++;
    end
  endtask

  always @(negedge s4_clk) begin
    byte_t lanes [enc_s4_pkg::OUT_SLOTS];
    int    n;
    lanes[0] = out_carry_bit_1;
    lanes[1] = out_carry_bit_2;
    lanes[2] = out_carry_bit_3;
    lanes[3] = out_carry_bit_4;
    lanes[4] = out_carry_bit_5;
    n        = out_carry_flag_bitstream;
    if (checking) begin
      check_last("output_flag_last", output_flag_last, flush_hist[2]);
      if (n > enc_s4_pkg::OUT_SLOTS) begin
        fail_cnt++;
        $display("ERROR %0t byte count %0d exceeds the five lanes", $time, n);
      end else if (n == 0) begin
        // Idle lanes must hold the previous strobe
        if (lanes_seen) begin
          for (int i = 0; i < enc_s4_pkg::OUT_SLOTS; i++) begin
            check_byte($sformatf("out_carry_bit_%0d", i + 1), lanes[i], prev_lanes[i]);
          end
        end
      end else begin
        for (int i = 0; i < n; i++) got_q.push_back(lanes[i]);
        prev_lanes = lanes;
        lanes_seen = 1'b1;
      end
      if (output_flag_last) begin
        if (n == 0) begin
          fail_cnt++;
          $display("ERROR %0t flush tail strobe carries no bytes", $time);
        end
        finish_stream();
      end
    end
  end

  // ---------------------------------------------------------------------
  // Main sequence
  // ---------------------------------------------------------------------
  initial begin
    int wait_cycles;
    bit timed_out;
    void'($urandom(SEED));
    rst_n                = 1'b0;
    flush                = 1'b0;
    // Chunks offered through reset and guard must never reach the FSM
    in_arith_flag        = enc_s4_pkg::CHUNK_TWO;
    in_arith_bitstream_1 = 16'h0155;
    in_arith_bitstream_2 = 16'h00AA;
    in_arith_low         = '0;
    in_arith_cnt         = '0;
    repeat (10) begin
      @(negedge s4_clk);
      check_count("out_carry_flag_bitstream", out_carry_flag_bitstream, '0);
      check_last("output_flag_last", output_flag_last, 1'b0);
    end
    rst_n = 1'b1;
    repeat (enc_s4_pkg::GUARD_CYCLES) begin
      @(negedge s4_clk);
      check_count("out_carry_flag_bitstream", out_carry_flag_bitstream, '0);
      check_last("output_flag_last", output_flag_last, 1'b0);
    end
    in_arith_flag        = enc_s4_pkg::CHUNK_NONE;
    in_arith_bitstream_1 = '0;
    in_arith_bitstream_2 = '0;
    checking = 1'b1;

    // Plain single chunks, then pairs with 0xFF runs and carries
    repeat (20) send_group(enc_s4_pkg::CHUNK_ONE, 1'b0, 1'b0);
    send_flush(5'd6, 1'b0);
    repeat (30) send_group(enc_s4_pkg::CHUNK_TWO, 1'b1, 1'b1);
    send_flush(5'd19, 1'b1);
    repeat (3) random_stream(150);

    wait_cycles = 0;
    while (streams_done < streams_sent && wait_cycles < TIMEOUT_CYCLES) begin
      @(negedge s4_clk);
      wait_cycles++;
    end
    timed_out = (streams_done < streams_sent);
    if (timed_out) begin
      $display("ERROR timeout with %0d of %0d streams finished", streams_done, streams_sent);
    end
    $display("Streams %0d, bytes %0d, mismatches %0d, other errors %0d",
             streams_done, bytes_checked, mismatch_cnt, fail_cnt + int'(timed_out));
    if (!timed_out && mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/carry_propagation.sv
// Carry FSM with held byte, pending 0xFF counter and five output byte lanes
`timescale 1ns/10ps
`default_nettype none

module carry_propagation (
  input  wire                               s4_clk,
  input  wire                               rst_n,
  input  wire                               carry_en,
  input  wire enc_s4_pkg::chunk_cnt_e       flag_in,
  input  wire                               drain,
  input  wire [enc_s4_pkg::RANGE_WIDTH-1:0] in_bitstream_1,
  input  wire [enc_s4_pkg::RANGE_WIDTH-1:0] in_bitstream_2,
  output logic [enc_s4_pkg::BYTE_WIDTH-1:0] out_bitstream_1,
  output logic [enc_s4_pkg::BYTE_WIDTH-1:0] out_bitstream_2,
  output logic [enc_s4_pkg::BYTE_WIDTH-1:0] out_bitstream_3,
  output logic [enc_s4_pkg::BYTE_WIDTH-1:0] out_bitstream_4,
  output logic [enc_s4_pkg::BYTE_WIDTH-1:0] out_bitstream_5,
  output logic [enc_s4_pkg::OUT_CNT_WIDTH-1:0] out_flag,
  output logic                              out_flag_last
);

  // ---------------------------------------------------------------------
  // State
  // ---------------------------------------------------------------------
  enc_s4_pkg::carry_state_e state;
  enc_s4_pkg::carry_state_e state_nxt;
  enc_s4_pkg::carry_state_e cur_state;

  logic [enc_s4_pkg::BYTE_WIDTH-1:0] held;
  logic [enc_s4_pkg::BYTE_WIDTH-1:0] held_nxt;
  logic [enc_s4_pkg::PEND_WIDTH-1:0] pend;
  logic [enc_s4_pkg::PEND_WIDTH-1:0] pend_nxt;

  // Gated request
  enc_s4_pkg::chunk_cnt_e flag_eff;
  logic                   drain_eff;

  logic [enc_s4_pkg::BYTE_WIDTH-1:0]    lane [enc_s4_pkg::OUT_SLOTS];
  logic [enc_s4_pkg::OUT_CNT_WIDTH-1:0] lane_cnt;
  logic                                 flag_last;

  // Nothing enters the FSM until the guard has expired
  assign flag_eff  = carry_en ? flag_in : enc_s4_pkg::CHUNK_NONE;
  assign drain_eff = carry_en & drain;
  // Drain cycle overrides whatever the register holds
  assign cur_state = drain_eff ? enc_s4_pkg::ST_DRAIN : state;

  // ---------------------------------------------------------------------
  // Chunk resolution, chunk 1 before chunk 2
  // ---------------------------------------------------------------------
  always_comb begin
    logic [enc_s4_pkg::RANGE_WIDTH-1:0] chunk;
    logic                               chunk_valid;
    logic                               carry;
    state_nxt = state;
    held_nxt  = held;
    pend_nxt  = pend;
    lane_cnt  = '0;
    flag_last = 1'b0;
    for (int i = 0; i < enc_s4_pkg::OUT_SLOTS; i++) begin
      lane[i] = '0;
    end
    unique case (cur_state)
      enc_s4_pkg::ST_DRAIN: begin
        // Flush tail: held byte, then the 0xFF run nobody resolved
        if (state == enc_s4_pkg::ST_HOLD) begin
          lane[lane_cnt] = held;
          lane_cnt       = lane_cnt + 1'b1;
          for (int p = 0; p < enc_s4_pkg::MAX_PENDING; p++) begin
            if (p < pend) begin
              lane[lane_cnt] = '1;
              lane_cnt       = lane_cnt + 1'b1;
            end
          end
        end
        state_nxt = enc_s4_pkg::ST_EMPTY;
        pend_nxt  = '0;
        flag_last = 1'b1;
      end
      default: begin
        for (int c = 0; c < 2; c++) begin
          chunk       = (c == 0) ? in_bitstream_1 : in_bitstream_2;
          chunk_valid = (c == 0) ? (flag_eff != enc_s4_pkg::CHUNK_NONE) :
                                   (flag_eff == enc_s4_pkg::CHUNK_TWO);
          carry       = chunk[enc_s4_pkg::BYTE_WIDTH];
          if (chunk_valid) begin
            if (state_nxt == enc_s4_pkg::ST_EMPTY) begin
              // First byte of a stream is only parked
              held_nxt  = chunk[enc_s4_pkg::BYTE_WIDTH-1:0];
              state_nxt = enc_s4_pkg::ST_HOLD;
            end else if (chunk == enc_s4_pkg::FF_CHUNK) begin
              pend_nxt = pend_nxt + 1'b1;
            end else begin
              lane[lane_cnt] = held_nxt + enc_s4_pkg::BYTE_WIDTH'(carry);
              lane_cnt       = lane_cnt + 1'b1;
              // Carry turns each pending 0xFF into 0x00
              for (int p = 0; p < enc_s4_pkg::MAX_PENDING; p++) begin
                if (p < pend_nxt) begin
                  lane[lane_cnt] = {enc_s4_pkg::BYTE_WIDTH{~carry}};
                  lane_cnt       = lane_cnt + 1'b1;
                end
              end
              held_nxt = chunk[enc_s4_pkg::BYTE_WIDTH-1:0];
              pend_nxt = '0;
            end
          end
        end
      end
    endcase
  end

  // ---------------------------------------------------------------------
  // Registers
  // ---------------------------------------------------------------------
  always_ff @(posedge s4_clk) begin
    if (!rst_n) begin
      state <= enc_s4_pkg::ST_EMPTY;
      pend  <= '0;
    end else begin
      state <= state_nxt;
      pend  <= pend_nxt;
    end
  end

  always_ff @(posedge s4_clk) begin
    held <= held_nxt;
  end

  assign out_bitstream_1 = lane[0];
  assign out_bitstream_2 = lane[1];
  assign out_bitstream_3 = lane[2];
  assign out_bitstream_4 = lane[3];
  assign out_bitstream_5 = lane[4];
  assign out_flag        = lane_cnt;
  assign out_flag_last   = flag_last;

  // ---------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------
  a_pend_limit: assert property (
    @(posedge s4_clk) disable iff (!rst_n)
    pend <= enc_s4_pkg::MAX_PENDING
  );

  // Nothing is held yet, so a carry would have no byte to land in
  a_no_carry_when_empty: assert property (
    @(posedge s4_clk) disable iff (!rst_n)
    (cur_state == enc_s4_pkg::ST_EMPTY && flag_eff != enc_s4_pkg::CHUNK_NONE)
      |-> !in_bitstream_1[enc_s4_pkg::BYTE_WIDTH]
  );

  a_lane_limit: assert property (
    @(posedge s4_clk) disable iff (!rst_n)
    lane_cnt <= enc_s4_pkg::OUT_SLOTS
  );

endmodule

`default_nettype wire

//--- verilog/enc_s4_pkg.sv
// Shared widths, limits and enums for the stage 4 carry and final bits logic
`default_nettype none

package enc_s4_pkg;

  // ---------------------------------------------------------------------
  // Data widths
  // ---------------------------------------------------------------------
  // One chunk from the encoder core: carry in bit 8, byte in bits 7..0
  localparam int RANGE_WIDTH = 16;
  localparam int LOW_WIDTH   = 24;
  localparam int D_SIZE      = 5;
  localparam int BYTE_WIDTH  = 8;

  // ---------------------------------------------------------------------
  // Limits
  // ---------------------------------------------------------------------
  localparam int MAX_PENDING   = 3;
  localparam int OUT_SLOTS     = 5;
  localparam int OUT_CNT_WIDTH = 3;
  localparam int GUARD_CYCLES  = 4;

  // Pending counter keeps one spare count so an overflow stays visible
  localparam int PEND_WIDTH      = $clog2(MAX_PENDING + 2);
  localparam int GUARD_CNT_WIDTH = $clog2(GUARD_CYCLES + 1);

  // Chunk that only extends the run of pending 0xFF bytes
  localparam logic [RANGE_WIDTH-1:0] FF_CHUNK = 16'h00FF;

  // ---------------------------------------------------------------------
  // Enums
  // ---------------------------------------------------------------------
  typedef enum logic [1:0] {
    CHUNK_NONE = 2'd0,
    CHUNK_ONE  = 2'd1,
    CHUNK_TWO  = 2'd2
  } chunk_cnt_e;

  typedef enum logic [1:0] {
    ST_EMPTY = 2'd0,
    ST_HOLD  = 2'd1,
    ST_DRAIN = 2'd2
  } carry_state_e;

endpackage

`default_nettype wire

//--- verilog/final_bits_generator.sv
// Final chunk builder from the closing low register and bit count
`timescale 1ns/10ps
`default_nettype none

module final_bits_generator (
  input  wire [enc_s4_pkg::LOW_WIDTH-1:0] in_low,
  input  wire [enc_s4_pkg::D_SIZE-1:0]    in_cnt,
  output enc_s4_pkg::chunk_cnt_e          final_flag,
  output logic [enc_s4_pkg::RANGE_WIDTH-1:0] out_bit_1,
  output logic [enc_s4_pkg::RANGE_WIDTH-1:0] out_bit_2
);

  // Top nine bits of low: carry at low[23], byte at low[22:15]
  logic [enc_s4_pkg::BYTE_WIDTH:0]   top_bits;
  // Next byte down, low[14:7], never carries
  logic [enc_s4_pkg::BYTE_WIDTH-1:0] next_byte;

  assign top_bits  = in_low[enc_s4_pkg::LOW_WIDTH-1 -: enc_s4_pkg::BYTE_WIDTH + 1];
  assign next_byte = in_low[enc_s4_pkg::LOW_WIDTH-enc_s4_pkg::BYTE_WIDTH-2 -:
                            enc_s4_pkg::BYTE_WIDTH];

  always_comb begin
    out_bit_1 = enc_s4_pkg::RANGE_WIDTH'(top_bits);
    out_bit_2 = enc_s4_pkg::RANGE_WIDTH'(next_byte);
    // A second byte only carries information past eight pending bits
    if (in_cnt <= enc_s4_pkg::BYTE_WIDTH) begin
      final_flag = enc_s4_pkg::CHUNK_ONE;
    end else begin
      final_flag = enc_s4_pkg::CHUNK_TWO;
    end
  end

endmodule

`default_nettype wire

//--- verilog/s4_reset_control.sv
// Output guard counter that keeps the carry logic disabled right after reset
`timescale 1ns/10ps
`default_nettype none

module s4_reset_control (
  input  wire  s4_clk,
  input  wire  rst_n,
  output logic carry_en
);

  logic [enc_s4_pkg::GUARD_CNT_WIDTH-1:0] guard_cnt;

  // Saturates at GUARD_CYCLES, counting edges since rst_n went high
  always_ff @(posedge s4_clk) begin
    if (!rst_n) begin
      guard_cnt <= '0;
    end else if (guard_cnt != enc_s4_pkg::GUARD_CYCLES) begin
      guard_cnt <= guard_cnt + 1'b1;
    end
  end

  // The encoder core may still emit garbage while its own reset settles
  assign carry_en = (guard_cnt == enc_s4_pkg::GUARD_CYCLES);

endmodule

`default_nettype wire

//--- verilog/stage_4.sv
// Stage 4 top: flush sequencing, final chunk mux, carry FSM and output registers
`timescale 1ns/10ps
`default_nettype none

module stage_4 (
  input  wire                               s4_clk,
  input  wire                               rst_n,
  input  wire                               flush,
  input  wire enc_s4_pkg::chunk_cnt_e       in_arith_flag,
  input  wire [enc_s4_pkg::RANGE_WIDTH-1:0] in_arith_bitstream_1,
  input  wire [enc_s4_pkg::RANGE_WIDTH-1:0] in_arith_bitstream_2,
  input  wire [enc_s4_pkg::LOW_WIDTH-1:0]   in_arith_low,
  input  wire [enc_s4_pkg::D_SIZE-1:0]      in_arith_cnt,
  output logic [enc_s4_pkg::BYTE_WIDTH-1:0] out_carry_bit_1,
  output logic [enc_s4_pkg::BYTE_WIDTH-1:0] out_carry_bit_2,
  output logic [enc_s4_pkg::BYTE_WIDTH-1:0] out_carry_bit_3,
  output logic [enc_s4_pkg::BYTE_WIDTH-1:0] out_carry_bit_4,
  output logic [enc_s4_pkg::BYTE_WIDTH-1:0] out_carry_bit_5,
  output logic [enc_s4_pkg::OUT_CNT_WIDTH-1:0] out_carry_flag_bitstream,
  output logic                              output_flag_last
);

  logic carry_en;

  // Final chunks, combinational and captured on flush
  enc_s4_pkg::chunk_cnt_e             fin_flag;
  enc_s4_pkg::chunk_cnt_e             fin_flag_q;
  logic [enc_s4_pkg::RANGE_WIDTH-1:0] fin_bit_1;
  logic [enc_s4_pkg::RANGE_WIDTH-1:0] fin_bit_2;
  logic [enc_s4_pkg::RANGE_WIDTH-1:0] fin_bit_1_q;
  logic [enc_s4_pkg::RANGE_WIDTH-1:0] fin_bit_2_q;

  // flush_d1 marks the final-processing cycle, flush_d2 the drain
  logic flush_d1;
  logic flush_d2;

  enc_s4_pkg::chunk_cnt_e             mux_flag;
  logic [enc_s4_pkg::RANGE_WIDTH-1:0] mux_bit_1;
  logic [enc_s4_pkg::RANGE_WIDTH-1:0] mux_bit_2;

  logic [enc_s4_pkg::BYTE_WIDTH-1:0]    carry_bit_1;
  logic [enc_s4_pkg::BYTE_WIDTH-1:0]    carry_bit_2;
  logic [enc_s4_pkg::BYTE_WIDTH-1:0]    carry_bit_3;
  logic [enc_s4_pkg::BYTE_WIDTH-1:0]    carry_bit_4;
  logic [enc_s4_pkg::BYTE_WIDTH-1:0]    carry_bit_5;
  logic [enc_s4_pkg::OUT_CNT_WIDTH-1:0] carry_cnt;
  logic                                 carry_last;

  s4_reset_control u_reset_ctrl (
    .s4_clk   (s4_clk),
    .rst_n    (rst_n),
    .carry_en (carry_en)
  );

  final_bits_generator u_final_bits (
    .in_low     (in_arith_low),
    .in_cnt     (in_arith_cnt),
    .final_flag (fin_flag),
    .out_bit_1  (fin_bit_1),
    .out_bit_2  (fin_bit_2)
  );

  // ---------------------------------------------------------------------
  // Flush sequencing
  // ---------------------------------------------------------------------
  always_ff @(posedge s4_clk) begin
    if (flush) begin
      fin_flag_q  <= fin_flag;
      fin_bit_1_q <= fin_bit_1;
      fin_bit_2_q <= fin_bit_2;
    end
  end

  always_ff @(posedge s4_clk) begin
    if (!rst_n) begin
      flush_d1 <= 1'b0;
      flush_d2 <= 1'b0;
    end else begin
      flush_d1 <= flush;
      flush_d2 <= flush_d1;
    end
  end

  // Core chunks normally, captured final chunks one cycle after flush
  assign mux_flag  = flush_d1 ? fin_flag_q  : in_arith_flag;
  assign mux_bit_1 = flush_d1 ? fin_bit_1_q : in_arith_bitstream_1;
  assign mux_bit_2 = flush_d1 ? fin_bit_2_q : in_arith_bitstream_2;

  carry_propagation u_carry (
    .s4_clk          (s4_clk),
    .rst_n           (rst_n),
    .carry_en        (carry_en),
    .flag_in         (mux_flag),
    .drain           (flush_d2),
    .in_bitstream_1  (mux_bit_1),
    .in_bitstream_2  (mux_bit_2),
    .out_bitstream_1 (carry_bit_1),
    .out_bitstream_2 (carry_bit_2),
    .out_bitstream_3 (carry_bit_3),
    .out_bitstream_4 (carry_bit_4),
    .out_bitstream_5 (carry_bit_5),
    .out_flag        (carry_cnt),
    .out_flag_last   (carry_last)
  );

  // ---------------------------------------------------------------------
  // Output registers
  // ---------------------------------------------------------------------
  // Lanes hold their last bytes between strobes
  always_ff @(posedge s4_clk) begin
    if (carry_cnt != '0) begin
      out_carry_bit_1 <= carry_bit_1;
      out_carry_bit_2 <= carry_bit_2;
      out_carry_bit_3 <= carry_bit_3;
      out_carry_bit_4 <= carry_bit_4;
      out_carry_bit_5 <= carry_bit_5;
    end
  end

  always_ff @(posedge s4_clk) begin
    if (!rst_n) begin
      out_carry_flag_bitstream <= '0;
      output_flag_last         <= 1'b0;
    end else begin
      out_carry_flag_bitstream <= carry_cnt;
      output_flag_last         <= carry_last;
    end
  end

  // ---------------------------------------------------------------------
  // Input protocol
  // ---------------------------------------------------------------------
  // Final chunks own the carry FSM for the flush cycle and the two after it
  a_quiet_around_flush: assert property (
    @(posedge s4_clk) disable iff (!rst_n)
    flush |-> (in_arith_flag == enc_s4_pkg::CHUNK_NONE) [*3]
  );

endmodule

`default_nettype wire
